// File: logic/ufi_params.svh
// UFI bus parameters
// Bus widths, RAM decode depth, read latency, owner queue depth
`ifndef UFI_PARAMS_SVH
`define UFI_PARAMS_SVH

// ------------------------------
// Bus widths
`define UFI_DATA_W         8    // Data word, matches external RAM width
`define UFI_ADRS_W         32   // Full bus address

// ------------------------------
// On-chip RAM
`define UFI_RAM_DEPTH_BITS 10   // Decoded address bits, upper bits ignored
`define UFI_RAM_LATENCY    2    // Read stages after the command is sampled

// Read router owner FIFO, at least latency plus 1
`define UFI_QUEUE_DEPTH    4

`endif

// File: logic/ufiBusPkg.sv
// UFI bus control types
// Requester owner codes and bus command encoding
package ufiBusPkg;

	// ------------------------------
	// Bus holder / read owner
	// Order follows arbiter priority
	typedef enum logic [1:0]
	{
		ownMcs = 2'd0,  // Microcontroller, write only
		ownSpi = 2'd1,  // SPI debug, read and write
		ownAtb = 2'd2,  // Audio transfer, read only
		ownVtb = 2'd3   // Video transfer, frame buffer R/W
	} ufiOwnerT;

	// ------------------------------
	// Command toward the RAM
	typedef enum logic
	{
		cmdWrite = 1'b0,
		cmdRead  = 1'b1
	} ufiCmdT;

	// Low level is write, same as requester cmd pins

endpackage

// File: logic/ufiMemPkg.sv
// UFI memory word types
// Data word and address, sized from the params header
`include "ufi_params.svh"

package ufiMemPkg;

	// ------------------------------
	// Data word on wd and rd
	typedef logic [`UFI_DATA_W-1:0] ufiDataT;

	// ------------------------------
	// Shared read/write address
	// RAM decodes only the low bits
	typedef logic [`UFI_ADRS_W-1:0] ufiAdrsT;

endpackage

// File: logic/ufiSlaveIf.sv
// UFI slave side interface
// Arbiter to RAM command, RAM return, router monitor view
`timescale 1ns/1ps

interface ufiSlaveIf;
	import ufiBusPkg::*;
	import ufiMemPkg::*;

	// Arbiter -> RAM, registered command
	ufiDataT  wd;       // Write data
	ufiAdrsT  adrs;     // R/W address
	logic     wEd;      // Write strobe
	logic     rEd;      // Read strobe
	ufiCmdT   cmd;      // High read / low write
	ufiOwnerT owner;    // Requester holding the bus

	// RAM -> arbiter / router
	ufiDataT  rd;       // Read data
	logic     rdValid;  // Read data valid
	logic     rdy;      // RAM accepts commands

	// ------------------------------
	modport master  (output wd, adrs, wEd, rEd, cmd, owner,
	                 input  rd, rdValid, rdy);

	modport slave   (input  wd, adrs, wEd, rEd, cmd, owner,
	                 output rd, rdValid, rdy);

	// Router only watches read issue and return
	modport monitor (input rEd, owner, rd, rdValid);

endinterface

// File: logic/ufiArbiter.sv
// UFI fixed-priority arbiter
// MCS > SPI > ATB / VTB, ATB and VTB lock each other out
// Winner command registered onto the slave interface
`timescale 1ns/1ps

module ufiArbiter (
	input  logic                iUfiClk,
	input  logic                rstN,
	// MCS, write only
	input  ufiMemPkg::ufiDataT  mcsWd,
	input  ufiMemPkg::ufiAdrsT  mcsAdrs,
	input  logic                mcsEd,
	input  logic                mcsVd,
	// SPI debug, R/W
	input  ufiMemPkg::ufiDataT  spiWd,
	input  ufiMemPkg::ufiAdrsT  spiAdrs,
	input  logic                spiEd,
	input  logic                spiVd,
	input  ufiBusPkg::ufiCmdT   spiCmd,
	// VTB, R/W with split strobes
	input  ufiMemPkg::ufiDataT  vtbWd,
	input  ufiMemPkg::ufiAdrsT  vtbAdrs,
	input  logic                vtbWEd,
	input  logic                vtbREd,
	input  logic                vtbVd,
	input  ufiBusPkg::ufiCmdT   vtbCmd,
	// ATB, read only
	input  ufiMemPkg::ufiAdrsT  atbAdrs,
	input  logic                atbEd,
	input  logic                atbVd,
	// Registered grants
	output logic                atbRdy,
	output logic                vtbRdy,
	ufiSlaveIf.master           bus
);
	import ufiBusPkg::*;
	import ufiMemPkg::*;

	logic     hiBusy;    // MCS or SPI takes the bus
	logic     atbWin;    // ATB owns the ATB/VTB pair
	logic     vtbWin;
	logic     vtbLock;   // VTB held the pair last clock
	ufiDataT  nxtWd;
	ufiAdrsT  nxtAdrs;
	logic     nxtWEd;
	logic     nxtREd;
	ufiCmdT   nxtCmd;
	ufiOwnerT nxtOwner;

	// ------------------------------
	// Lockout, holder keeps pair until its valid drops
	assign hiBusy = mcsVd || spiVd;
	assign atbWin = atbVd && !vtbLock;      // ATB first when both idle
	assign vtbWin = vtbVd && !atbWin;

	// ------------------------------
	// Winner select
	always_comb
	begin
		nxtWd    = '0;                       // Idle bus
		nxtAdrs  = '0;
		nxtWEd   = 1'b0;
		nxtREd   = 1'b0;
		nxtCmd   = cmdWrite;
		nxtOwner = ownMcs;
		if (bus.rdy)                         // Nothing issued before RAM is up
		begin
			if (mcsVd)
			begin
				nxtWd    = mcsWd;
				nxtAdrs  = mcsAdrs;
				nxtWEd   = mcsEd;            // MCS write fixed
			end
			else if (spiVd)
			begin
				nxtWd    = spiWd;
				nxtAdrs  = spiAdrs;
				nxtWEd   = spiEd && (spiCmd == cmdWrite);
				nxtREd   = spiEd && (spiCmd == cmdRead);
				nxtCmd   = spiCmd;
				nxtOwner = ownSpi;
			end
			else if (atbWin)
			begin
				nxtAdrs  = atbAdrs;
				nxtREd   = atbEd;            // ATB enable is a read strobe
				nxtCmd   = cmdRead;
				nxtOwner = ownAtb;
			end
			else if (vtbWin)
			begin
				nxtWd    = vtbWd;
				nxtAdrs  = vtbAdrs;
				nxtWEd   = vtbWEd;
				nxtREd   = vtbREd;
				nxtCmd   = vtbCmd;
				nxtOwner = ownVtb;
			end
		end
	end

	// Control state
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			bus.wEd <= 1'b0;
			bus.rEd <= 1'b0;
			atbRdy  <= 1'b0;
			vtbRdy  <= 1'b0;
			vtbLock <= 1'b0;
		end
		else
		begin
			bus.wEd <= nxtWEd;
			bus.rEd <= nxtREd;
			atbRdy  <= atbWin && !hiBusy && bus.rdy;   // Low while preempted
			vtbRdy  <= vtbWin && !hiBusy && bus.rdy;
			vtbLock <= vtbWin;
		end
	end

	// Payload
	always_ff @(posedge iUfiClk)
	begin
		bus.wd    <= nxtWd;
		bus.adrs  <= nxtAdrs;
		bus.cmd   <= nxtCmd;
		bus.owner <= nxtOwner;
	end

	// One access per clock on the shared RAM port
	aNoRdWr: assert property (@(posedge iUfiClk) disable iff (!rstN)
		!(bus.wEd && bus.rEd))
		else $error("wEd and rEd high together");

endmodule

// File: logic/ufiRamBlock.sv
// UFI on-chip RAM slave
// Single port array, pipelined read, ready level
`timescale 1ns/1ps
`include "ufi_params.svh"

module ufiRamBlock (
	input  logic      iUfiClk,
	input  logic      rstN,
	ufiSlaveIf.slave  bus
);
	import ufiBusPkg::*;
	import ufiMemPkg::*;

	localparam int depth = 1 << `UFI_RAM_DEPTH_BITS;
	localparam int lat   = `UFI_RAM_LATENCY;

	ufiDataT                       mem [depth];
	ufiDataT                       rdPipe [lat];  // Data stages
	logic [lat-1:0]                vldPipe;       // Valid stages
	logic [`UFI_RAM_DEPTH_BITS-1:0] ramAdrs;
	logic [`UFI_RAM_DEPTH_BITS-1:0] ramAdrsQ;      // Sampled read address
	logic                          rdEnQ;         // Sampled read strobe

	assign ramAdrs = bus.adrs[`UFI_RAM_DEPTH_BITS-1:0];   // Upper bits ignored

	// Up one clock after reset release
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
			bus.rdy <= 1'b0;
		else
			bus.rdy <= 1'b1;
	end

	// ------------------------------
	// Write port
	always_ff @(posedge iUfiClk)
	begin
		if (bus.wEd && bus.rdy)
			mem[ramAdrs] <= bus.wd;
	end

	// Read pipeline, several reads may be in flight
	always_ff @(posedge iUfiClk)
	begin
		ramAdrsQ  <= ramAdrs;
		rdPipe[0] <= mem[ramAdrsQ];
		for (int i = 1; i < lat; i++)
			rdPipe[i] <= rdPipe[i-1];
	end

	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			rdEnQ   <= 1'b0;
			vldPipe <= '0;
		end
		else
		begin
			rdEnQ   <= bus.rEd && bus.rdy;
			vldPipe <= (vldPipe << 1) | lat'(rdEnQ);
		end
	end

	assign bus.rd      = rdPipe[lat-1];
	assign bus.rdValid = vldPipe[lat-1];

	// Sample edge, then lat stages
	aRdLat: assert property (@(posedge iUfiClk) disable iff (!rstN)
		(bus.rEd && bus.rdy) |-> ##(lat+1) bus.rdValid)
		else $error("rdValid missing after read");
	aNoStrayVld: assert property (@(posedge iUfiClk) disable iff (!rstN)
		bus.rdValid |-> $past(bus.rEd && bus.rdy, lat+1))
		else $error("rdValid without matching read");

	// Command code agrees with the strobe
	aCmdCode: assert property (@(posedge iUfiClk) disable iff (!rstN)
		bus.rEd |-> bus.cmd == cmdRead)
		else $error("rEd with write command");

endmodule

// File: logic/ufiReadRouter.sv
// UFI read router
// Owner FIFO for outstanding reads, registered tagged return
`timescale 1ns/1ps
`include "ufi_params.svh"

module ufiReadRouter (
	input  logic                 iUfiClk,
	input  logic                 rstN,
	ufiSlaveIf.monitor           bus,
	output ufiMemPkg::ufiDataT   rd,
	output logic                 rdValid,
	output ufiBusPkg::ufiOwnerT  rdOwner
);
	import ufiBusPkg::*;

	localparam int qDepth = `UFI_QUEUE_DEPTH;
	localparam int ptrW   = $clog2(qDepth);

	ufiOwnerT      ownQ [qDepth];   // Issuer of each read in flight
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [ptrW:0]   qCount;
	logic          qFull;
	logic          qEmpty;
	logic          push;
	logic          pop;

	// Whole read latency must fit in the FIFO
	if (qDepth < `UFI_RAM_LATENCY + 1)
		$error("UFI_QUEUE_DEPTH below read latency plus 1");

	assign qFull  = (qCount == (ptrW+1)'(qDepth));
	assign qEmpty = (qCount == '0);
	assign push   = bus.rEd && !qFull;        // Dropped when full
	assign pop    = bus.rdValid && !qEmpty;

	// ------------------------------
	// Owner FIFO
	always_ff @(posedge iUfiClk)
	begin
		if (push)
			ownQ[wrPtr] <= bus.owner;
	end

	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			qCount  <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == ptrW'(qDepth-1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(qDepth-1)) ? '0 : rdPtr + 1'b1;
			qCount  <= qCount + push - pop;   // Push and pop may coincide
			rdValid <= pop;
		end
	end

	// Tagged return
	always_ff @(posedge iUfiClk)
	begin
		rd <= bus.rd;
		if (pop)
			rdOwner <= ownQ[rdPtr];
	end

	aNoOvf: assert property (@(posedge iUfiClk) disable iff (!rstN)
		bus.rEd |-> !qFull) else $error("owner FIFO overflow, read dropped");
	aNoUnf: assert property (@(posedge iUfiClk) disable iff (!rstN)
		bus.rdValid |-> !qEmpty) else $error("rdValid with no owner queued");

endmodule

// File: logic/ufiMemSubsystem.sv
// UFI memory subsystem top
// Arbiter, on-chip RAM and read router on one slave interface
`timescale 1ns/1ps

module ufiMemSubsystem (
	input  logic                 iUfiClk,
	input  logic                 rstN,
	// MCS
	input  ufiMemPkg::ufiDataT   mcsWd,
	input  ufiMemPkg::ufiAdrsT   mcsAdrs,
	input  logic                 mcsEd,
	input  logic                 mcsVd,
	// SPI
	input  ufiMemPkg::ufiDataT   spiWd,
	input  ufiMemPkg::ufiAdrsT   spiAdrs,
	input  logic                 spiEd,
	input  logic                 spiVd,
	input  ufiBusPkg::ufiCmdT    spiCmd,
	// VTB
	input  ufiMemPkg::ufiDataT   vtbWd,
	input  ufiMemPkg::ufiAdrsT   vtbAdrs,
	input  logic                 vtbWEd,
	input  logic                 vtbREd,
	input  logic                 vtbVd,
	input  ufiBusPkg::ufiCmdT    vtbCmd,
	// ATB
	input  ufiMemPkg::ufiAdrsT   atbAdrs,
	input  logic                 atbEd,
	input  logic                 atbVd,
	output logic                 atbRdy,
	output logic                 vtbRdy,
	// Read return, tagged with owner
	output ufiMemPkg::ufiDataT   rd,
	output logic                 rdValid,
	output ufiBusPkg::ufiOwnerT  rdOwner,
	output logic                 busRdy       // RAM ready level
);

	ufiSlaveIf ufiBus ();

	assign busRdy = ufiBus.rdy;

	// ------------------------------
	// Requesters -> RAM command
	ufiArbiter arbiter (
		.iUfiClk (iUfiClk),
		.rstN    (rstN),
		.mcsWd   (mcsWd),
		.mcsAdrs (mcsAdrs),
		.mcsEd   (mcsEd),
		.mcsVd   (mcsVd),
		.spiWd   (spiWd),
		.spiAdrs (spiAdrs),
		.spiEd   (spiEd),
		.spiVd   (spiVd),
		.spiCmd  (spiCmd),
		.vtbWd   (vtbWd),
		.vtbAdrs (vtbAdrs),
		.vtbWEd  (vtbWEd),
		.vtbREd  (vtbREd),
		.vtbVd   (vtbVd),
		.vtbCmd  (vtbCmd),
		.atbAdrs (atbAdrs),
		.atbEd   (atbEd),
		.atbVd   (atbVd),
		.atbRdy  (atbRdy),
		.vtbRdy  (vtbRdy),
		.bus     (ufiBus.master)
	);

	ufiRamBlock ramBlock (
		.iUfiClk (iUfiClk),
		.rstN    (rstN),
		.bus     (ufiBus.slave)
	);

	// Return path, owner lookup
	ufiReadRouter readRouter (
		.iUfiClk (iUfiClk),
		.rstN    (rstN),
		.bus     (ufiBus.monitor),
		.rd      (rd),
		.rdValid (rdValid),
		.rdOwner (rdOwner)
	);

endmodule

// File: verif/tbUfiTasks.svh
// UFI testbench tasks
// Clock step, LFSR bits, requester drivers, grant and drain waits
// Directed tests for reset, SPI readback, priority, lockout, routing

// ------------------------------
// Helpers
task automatic stepClk();
	@(posedge iUfiClk);
	#1;                                   // Outputs settled, inputs driven here
endtask

function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;  // Galois taps 32,22,2,1
	else
		return s >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] randBits(input int n);
	logic [31:0] val;
	val = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsrState = lfsrNext(lfsrState);
		val = {val[30:0], lfsrState[0]};
	end
	return val;
endfunction

task automatic idleAll();
	mcsWd   = '0;
	mcsAdrs = '0;
	mcsEd   = 1'b0;
	mcsVd   = 1'b0;
	spiWd   = '0;
	spiAdrs = '0;
	spiEd   = 1'b0;
	spiVd   = 1'b0;
	spiCmd  = cmdWrite;
	vtbWd   = '0;
	vtbAdrs = '0;
	vtbWEd  = 1'b0;
	vtbREd  = 1'b0;
	vtbVd   = 1'b0;
	vtbCmd  = cmdWrite;
	atbAdrs = '0;
	atbEd   = 1'b0;
	atbVd   = 1'b0;
endtask

task automatic reportTest(input string name, input int errsBefore);
	if (errCount == errsBefore)
	begin
		$display("test %s passed", name);
		passCount++;
	end
	else
		$display("test %s failed with %0d errors", name, errCount - errsBefore);
	testCount++;
endtask

task automatic spiWrite(input ufiAdrsT adrs, input ufiDataT data);
	spiVd   = 1'b1;
	spiEd   = 1'b1;
	spiCmd  = cmdWrite;
	spiAdrs = adrs;
	spiWd   = data;
	refMem[adrs[`UFI_RAM_DEPTH_BITS-1:0]] = data;   // Upper bits not decoded
	stepClk();
endtask

// Single read, return latency measured from the sampling edge
task automatic spiRead(input ufiAdrsT adrs);
	int waited;
	spiVd   = 1'b1;
	spiEd   = 1'b1;
	spiCmd  = cmdRead;
	spiAdrs = adrs;
	expOwner.push_back(ownSpi);
	expData.push_back(refMem[adrs[`UFI_RAM_DEPTH_BITS-1:0]]);
	stepClk();                            // Arbiter samples strobe
	spiVd  = 1'b0;
	spiEd  = 1'b0;
	waited = 0;
	while (rdValid !== 1'b1 && waited < 16)
	begin
		stepClk();
		waited++;
	end
	if (rdValid !== 1'b1)
	begin
		$display("SPI read got no return within 16 clocks");
		errCount++;
	end
	else if (waited != 4)
	begin
		$display("error readLatency exp %0h got %0h", 4, waited);
		errCount++;
	end
endtask

task automatic waitGrant(input ufiOwnerT who);
	int   waited;
	logic granted;
	waited  = 0;
	granted = 1'b0;
	while (granted !== 1'b1 && waited < 8)
	begin
		stepClk();
		waited++;
		granted = (who == ownAtb) ? atbRdy : vtbRdy;
	end
	if (granted !== 1'b1)
	begin
		$display("%s grant never arrived", who.name());
		errCount++;
	end
endtask

// Outstanding reads must all come back
task automatic drainReads();
	int waited;
	waited = 0;
	while (expOwner.size() != 0 && waited < 32)
	begin
		stepClk();
		waited++;
	end
	if (expOwner.size() != 0)
	begin
		$display("%0d read returns never arrived", expOwner.size());
		errCount++;
		expOwner.delete();
		expData.delete();
	end
endtask

// ------------------------------
// Directed tests
task automatic resetState();
	int errsBefore;
	int waited;
	errsBefore = errCount;
	if (rdValid !== 1'b0)
	begin
		$display("error rdValid exp %0h got %0h", 1'b0, rdValid);
		errCount++;
	end
	if (atbRdy !== 1'b0 || vtbRdy !== 1'b0)
	begin
		$display("error atbRdy/vtbRdy exp %0h got %0h", 2'b00, {atbRdy, vtbRdy});
		errCount++;
	end
	waited = 0;
	while (busRdy !== 1'b1 && waited < 4)
	begin
		stepClk();
		waited++;
	end
	if (busRdy !== 1'b1)
	begin
		$display("busRdy never went high after reset");
		errCount++;
	end
	reportTest("reset state", errsBefore);
endtask

task automatic spiReadback();
	int      errsBefore;
	ufiAdrsT adrs;
	errsBefore = errCount;
	for (int i = 0; i < 16; i++)
	begin
		adrs = randBits(32);              // Random upper bits too
		writtenAdrs.push_back(adrs);
		spiWrite(adrs, ufiDataT'(randBits(`UFI_DATA_W)));
	end
	idleAll();
	stepClk();
	foreach (writtenAdrs[i])
		spiRead(writtenAdrs[i]);
	drainReads();
	reportTest("spi readback", errsBefore);
endtask

// MCS and SPI write one address on the same clock
task automatic mcsPriority();
	int      errsBefore;
	ufiAdrsT adrs;
	ufiDataT mcsWord;
	errsBefore = errCount;
	adrs    = writtenAdrs[0];
	mcsWord = ufiDataT'(randBits(`UFI_DATA_W));
	mcsVd   = 1'b1;
	mcsEd   = 1'b1;
	mcsAdrs = adrs;
	mcsWd   = mcsWord;
	spiWrite(adrs, ~mcsWord);             // Loses, SPI word never lands
	refMem[adrs[`UFI_RAM_DEPTH_BITS-1:0]] = mcsWord;
	idleAll();
	stepClk();
	spiRead(adrs);
	drainReads();
	reportTest("mcs priority", errsBefore);
endtask

task automatic atbVtbLockout();
	int errsBefore;
	errsBefore = errCount;
	atbVd = 1'b1;
	stepClk();
	if (atbRdy !== 1'b1)
	begin
		$display("error atbRdy exp %0h got %0h", 1'b1, atbRdy);
		errCount++;
	end
	vtbVd = 1'b1;                         // Waits behind ATB
	repeat (4)
	begin
		stepClk();
		if (vtbRdy !== 1'b0)
		begin
			$display("error vtbRdy exp %0h got %0h", 1'b0, vtbRdy);
			errCount++;
		end
	end
	atbVd = 1'b0;
	stepClk();
	if (vtbRdy !== 1'b1 || atbRdy !== 1'b0)
	begin
		$display("error vtbRdy/atbRdy exp %0h got %0h", 2'b10, {vtbRdy, atbRdy});
		errCount++;
	end
	idleAll();
	stepClk();
	stepClk();
	reportTest("atb vtb lockout", errsBefore);
endtask

// Back-to-back VTB reads, then ATB reads, tags checked by monitor
task automatic readRouting();
	int      errsBefore;
	ufiAdrsT adrs;
	errsBefore = errCount;
	vtbVd  = 1'b1;
	vtbCmd = cmdRead;
	waitGrant(ownVtb);
	for (int i = 0; i < 8; i++)
	begin
		adrs    = writtenAdrs[randBits(4)];
		vtbREd  = 1'b1;
		vtbAdrs = adrs;
		expOwner.push_back(ownVtb);
		expData.push_back(refMem[adrs[`UFI_RAM_DEPTH_BITS-1:0]]);
		stepClk();
	end
	idleAll();
	atbVd = 1'b1;                         // VTB lock clears first
	waitGrant(ownAtb);
	for (int i = 0; i < 8; i++)
	begin
		adrs    = writtenAdrs[randBits(4)];
		atbEd   = 1'b1;
		atbAdrs = adrs;
		expOwner.push_back(ownAtb);
		expData.push_back(refMem[adrs[`UFI_RAM_DEPTH_BITS-1:0]]);
		stepClk();
	end
	idleAll();
	drainReads();
	reportTest("read routing", errsBefore);
endtask

// File: verif/tbUfiMem.sv
// UFI memory subsystem testbench top
// Clock, reset, DUT, LFSR, read return monitor, timeout, summary
// Directed tests come from the included task file
`timescale 1ns/1ps
`include "ufi_params.svh"

module tbUfiMem;
	import ufiBusPkg::*;
	import ufiMemPkg::*;

	localparam int ramWords   = 1 << `UFI_RAM_DEPTH_BITS;
	localparam int cycleLimit = 2000;      // Well above the whole test run

	logic     iUfiClk;
	logic     rstN;
	ufiDataT  mcsWd;
	ufiAdrsT  mcsAdrs;
	logic     mcsEd;
	logic     mcsVd;
	ufiDataT  spiWd;
	ufiAdrsT  spiAdrs;
	logic     spiEd;
	logic     spiVd;
	ufiCmdT   spiCmd;
	ufiDataT  vtbWd;
	ufiAdrsT  vtbAdrs;
	logic     vtbWEd;
	logic     vtbREd;
	logic     vtbVd;
	ufiCmdT   vtbCmd;
	ufiAdrsT  atbAdrs;
	logic     atbEd;
	logic     atbVd;
	logic     atbRdy;
	logic     vtbRdy;
	ufiDataT  rd;
	logic     rdValid;
	ufiOwnerT rdOwner;
	logic     busRdy;

	// ------------------------------
	// Reference model state
	ufiDataT     refMem [ramWords];   // Mirrors the on-chip RAM
	ufiAdrsT     writtenAdrs [$];     // Addresses holding known data
	ufiOwnerT    expOwner [$];        // Issuer of each outstanding read
	ufiDataT     expData [$];
	logic [31:0] lfsrState = 32'hb00b_f235;
	int          errCount  = 0;
	int          testCount = 0;
	int          passCount = 0;
	int          cycleCount;

	ufiMemSubsystem i_ufiMemSubsystem (.*);

	`include "tbUfiTasks.svh"

	initial
	begin
		iUfiClk = 1'b0;
		forever #4 iUfiClk = ~iUfiClk;   // 8 ns period
	end

	// Returns checked mid-cycle, in issue order
	always @(negedge iUfiClk)
	begin
		if (rstN && rdValid === 1'b1)
		begin
			if (expOwner.size() == 0)
			begin
				$display("read return arrived with no read outstanding");
				errCount++;
			end
			else
			begin
				if (rdOwner !== expOwner[0])
				begin
					$display("error rdOwner exp %0h got %0h", expOwner[0], rdOwner);
					errCount++;
				end
				if (rd !== expData[0])
				begin
					$display("error rd exp %0h got %0h", expData[0], rd);
					errCount++;
				end
				void'(expOwner.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	// ------------------------------
	// Run limit
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge iUfiClk);
			cycleCount++;
		end
		$display("run stopped after %0d cycles without finishing", cycleLimit);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		idleAll();
		rstN = 1'b0;
		repeat (5) @(posedge iUfiClk);   // 5 cycles in reset
		#1 rstN = 1'b1;
		resetState();
		spiReadback();
		mcsPriority();
		atbVtbLockout();
		readRouting();
		$display("%0d of %0d tests passed, %0d errors", passCount, testCount, errCount);
		if (errCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+logic
+incdir+verif
logic/ufiBusPkg.sv
logic/ufiMemPkg.sv
logic/ufiSlaveIf.sv
logic/ufiArbiter.sv
logic/ufiRamBlock.sv
logic/ufiReadRouter.sv
logic/ufiMemSubsystem.sv
verif/tbUfiMem.sv

// File: Makefile
# Verilator build and run for the UFI memory subsystem testbench
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = tbUfiMem
FLIST    = flist.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(wildcard logic/*.sv logic/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJDIR)
